//--- vlog.f
+incdir+hw
hw/axi_pkg.sv
hw/arb_pkg.sv
hw/mem_delay_timer.sv
hw/axi_arbiter.sv
hw/axi_sram.sv
hw/mem_subsys_top.sv
tb/tb_mem_subsys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Regression passed
SOURCES   := $(FILELIST) $(wildcard hw/*.sv hw/*.svh tb/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_mem_subsys.sv
`timescale 1ns/1ps
`include "axi_macros.svh"

module tb_mem_subsys;
    import axi_pkg::*;

    localparam int N_TX      = 200;
    localparam int WD_CYCLES = 16 + 2 * N_TX * 40;
    localparam int PEND_NONE = 0;
    localparam int PEND_RD   = 1;
    localparam int PEND_WR   = 2;

    logic  clk;
    logic  rst;
    addr_t araddr  [2];
    logic  arvalid [2];
    logic  arready [2];
    data_t rdata   [2];
    resp_t rresp   [2];
    logic  rvalid  [2];
    logic  rready  [2];
    addr_t awaddr  [2];
    logic  awvalid [2];
    logic  awready [2];
    data_t wdata   [2];
    strb_t wstrb   [2];
    logic  wvalid  [2];
    logic  wready  [2];
    resp_t bresp   [2];
    logic  bvalid  [2];
    logic  bready  [2];

    logic [15:0] lfsr;
    logic        tx_wr    [2][N_TX];
    addr_t       tx_addr  [2][N_TX];
    data_t       tx_data  [2][N_TX];
    strb_t       tx_strb  [2][N_TX];
    int          tx_stall [2][N_TX];
    data_t       model    [`MEM_WORDS];
    strb_t       known    [`MEM_WORDS];   // bytes written so far.
    int          pend     [2];
    int          done_cnt [2];
    int          errors;
    int          checks;

    mem_subsys_top UUT (
        .clk        (clk),
        .rst        (rst),
        .m1_araddr  (araddr[0]),
        .m1_arvalid (arvalid[0]),
        .m1_arready (arready[0]),
        .m1_rdata   (rdata[0]),
        .m1_rresp   (rresp[0]),
        .m1_rvalid  (rvalid[0]),
        .m1_rready  (rready[0]),
        .m1_awaddr  (awaddr[0]),
        .m1_awvalid (awvalid[0]),
        .m1_awready (awready[0]),
        .m1_wdata   (wdata[0]),
        .m1_wstrb   (wstrb[0]),
        .m1_wvalid  (wvalid[0]),
        .m1_wready  (wready[0]),
        .m1_bresp   (bresp[0]),
        .m1_bvalid  (bvalid[0]),
        .m1_bready  (bready[0]),
        .m2_araddr  (araddr[1]),
        .m2_arvalid (arvalid[1]),
        .m2_arready (arready[1]),
        .m2_rdata   (rdata[1]),
        .m2_rresp   (rresp[1]),
        .m2_rvalid  (rvalid[1]),
        .m2_rready  (rready[1]),
        .m2_awaddr  (awaddr[1]),
        .m2_awvalid (awvalid[1]),
        .m2_awready (awready[1]),
        .m2_wdata   (wdata[1]),
        .m2_wstrb   (wstrb[1]),
        .m2_wvalid  (wvalid[1]),
        .m2_wready  (wready[1]),
        .m2_bresp   (bresp[1]),
        .m2_bvalid  (bvalid[1]),
        .m2_bready  (bready[1])
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic data_t byte_mask(input strb_t s);
        data_t m;
        for (int b = 0; b < `STRB_W; b++) begin
            m[8*b +: 8] = {8{s[b]}};
        end
        return m;
    endfunction

    task automatic make_stimulus();
        logic [7:0] word;
        lfsr = 16'd62;
        for (int i = 0; i < N_TX; i++) begin
            for (int m = 0; m < 2; m++) begin
                tx_wr[m][i] = 1'(take_bits(1));
                word        = 8'(take_bits(8));
                if (take_bits(1) != 0) begin
                    word[7:4] = 4'h0;            // hot set of 16 words.
                end
                tx_addr[m][i] = addr_t'({word, 2'b00});
                if (take_bits(3) == 0) begin
                    tx_addr[m][i] = tx_addr[m][i] + addr_t'(`MEM_WORDS * 4);
                end
                tx_data[m][i]  = data_t'(take_bits(32));
                tx_strb[m][i]  = strb_t'(take_bits(`STRB_W));
                tx_stall[m][i] = int'(take_bits(2));
            end
        end
    endtask

    task automatic run_master(input int m);
        data_t first;
        data_t got;
        data_t mask;
        data_t exp_data;
        resp_t exp_resp;
        logic  wr;
        logic  ok_addr;
        int    idx;
        for (int i = 0; i < N_TX; i++) begin
            wr       = tx_wr[m][i];
            ok_addr  = tx_addr[m][i] < addr_t'(`MEM_WORDS * 4);
            idx      = ok_addr ? int'(tx_addr[m][i] >> 2) : 0;
            exp_resp = ok_addr ? RESP_OKAY : RESP_SLVERR;
            @(posedge clk);
            #1;
            if (wr) begin
                awaddr[m]  = tx_addr[m][i];
                wdata[m]   = tx_data[m][i];
                wstrb[m]   = tx_strb[m][i];
                awvalid[m] = 1'b1;
                wvalid[m]  = 1'b1;
            end else begin
                araddr[m]  = tx_addr[m][i];
                arvalid[m] = 1'b1;
            end
            @(negedge clk);
            while (wr ? !(awready[m] && wready[m]) : !arready[m]) @(negedge clk);
            @(posedge clk);
            #1;
            arvalid[m] = 1'b0;
            awvalid[m] = 1'b0;
            wvalid[m]  = 1'b0;
            pend[m]    = wr ? PEND_WR : PEND_RD;
            rready[m]  = !wr && tx_stall[m][i] == 0;  // no stall, accept at once.
            bready[m]  = wr && tx_stall[m][i] == 0;
            @(negedge clk);
            while (!(wr ? bvalid[m] : rvalid[m])) @(negedge clk);
            first = wr ? data_t'(bresp[m]) : rdata[m];
            for (int k = 0; k < tx_stall[m][i]; k++) begin
                @(posedge clk);
                #1;
                if (k == tx_stall[m][i] - 1) begin
                    rready[m] = !wr;
                    bready[m] = wr;
                end
                @(negedge clk);
                got = wr ? data_t'(bresp[m]) : rdata[m];
                checks++;
                if (!(wr ? bvalid[m] : rvalid[m])) begin
                    errors++;
                    $display("m%0d response valid dropped before ready at %0t", m + 1, $time);
                end
                if (got !== first) begin
                    errors++;
                    $display("mismatch at %0t: m%0d_%s expected %h actual %h",
                             $time, m + 1, wr ? "bresp" : "rdata", first, got);
                end
            end
            checks++;
            if (wr) begin
                if (bresp[m] !== exp_resp) begin
                    errors++;
                    $display("mismatch at %0t: m%0d_bresp expected %h actual %h",
                             $time, m + 1, exp_resp, bresp[m]);
                end
                if (ok_addr) begin
                    mask       = byte_mask(tx_strb[m][i]);
                    model[idx] = (model[idx] & ~mask) | (tx_data[m][i] & mask);
                    known[idx] = known[idx] | tx_strb[m][i];
                end
            end else begin
                if (rresp[m] !== exp_resp) begin
                    errors++;
                    $display("mismatch at %0t: m%0d_rresp expected %h actual %h",
                             $time, m + 1, exp_resp, rresp[m]);
                end
                mask     = ok_addr ? byte_mask(known[idx]) : '1;  // unwritten bytes are unknown.
                exp_data = ok_addr ? model[idx] : '0;
                if ((rdata[m] & mask) !== (exp_data & mask)) begin
                    errors++;
                    $display("mismatch at %0t: m%0d_rdata expected %h actual %h",
                             $time, m + 1, exp_data & mask, rdata[m] & mask);
                end
            end
            @(posedge clk);
            #1;
            rready[m] = 1'b0;
            bready[m] = 1'b0;
            pend[m]   = PEND_NONE;
            done_cnt[m]++;
        end
    endtask

    // a response must belong to the outstanding request of that master.
    initial begin
        forever begin
            @(negedge clk);
            for (int m = 0; m < 2; m++) begin
                if (!rst && rvalid[m] && pend[m] != PEND_RD) begin
                    errors++;
                    $display("m%0d saw rvalid with no read outstanding at %0t", m + 1, $time);
                end
                if (!rst && bvalid[m] && pend[m] != PEND_WR) begin
                    errors++;
                    $display("m%0d saw bvalid with no write outstanding at %0t", m + 1, $time);
                end
            end
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        errors++;
        $display("timeout: transactions did not complete");
        for (int m = 0; m < 2; m++) begin
            $display("m%0d completed %0d of %0d transactions", m + 1, done_cnt[m], N_TX);
        end
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst    = 1'b1;
        errors = 0;
        checks = 0;
        for (int m = 0; m < 2; m++) begin
            araddr[m]   = '0;
            arvalid[m]  = 1'b0;
            rready[m]   = 1'b0;
            awaddr[m]   = '0;
            awvalid[m]  = 1'b0;
            wdata[m]    = '0;
            wstrb[m]    = '0;
            wvalid[m]   = 1'b0;
            bready[m]   = 1'b0;
            pend[m]     = PEND_NONE;
            done_cnt[m] = 0;
        end
        for (int w = 0; w < `MEM_WORDS; w++) begin
            model[w] = '0;
            known[w] = '0;
        end
        make_stimulus();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            run_master(0);
            run_master(1);
        join
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- hw/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic           clk,
    input  logic           rst,

    input  axi_pkg::addr_t m1_araddr,
    input  logic           m1_arvalid,
    output logic           m1_arready,
    output axi_pkg::data_t m1_rdata,
    output axi_pkg::resp_t m1_rresp,
    output logic           m1_rvalid,
    input  logic           m1_rready,
    input  axi_pkg::addr_t m1_awaddr,
    input  logic           m1_awvalid,
    output logic           m1_awready,
    input  axi_pkg::data_t m1_wdata,
    input  axi_pkg::strb_t m1_wstrb,
    input  logic           m1_wvalid,
    output logic           m1_wready,
    output axi_pkg::resp_t m1_bresp,
    output logic           m1_bvalid,
    input  logic           m1_bready,

    input  axi_pkg::addr_t m2_araddr,
    input  logic           m2_arvalid,
    output logic           m2_arready,
    output axi_pkg::data_t m2_rdata,
    output axi_pkg::resp_t m2_rresp,
    output logic           m2_rvalid,
    input  logic           m2_rready,
    input  axi_pkg::addr_t m2_awaddr,
    input  logic           m2_awvalid,
    output logic           m2_awready,
    input  axi_pkg::data_t m2_wdata,
    input  axi_pkg::strb_t m2_wstrb,
    input  logic           m2_wvalid,
    output logic           m2_wready,
    output axi_pkg::resp_t m2_bresp,
    output logic           m2_bvalid,
    input  logic           m2_bready
);
    import axi_pkg::*;

    // shared bus between arbiter and memory.
    addr_t s_araddr;
    logic  s_arvalid;
    logic  s_arready;
    data_t s_rdata;
    resp_t s_rresp;
    logic  s_rvalid;
    logic  s_rready;
    addr_t s_awaddr;
    logic  s_awvalid;
    logic  s_awready;
    data_t s_wdata;
    strb_t s_wstrb;
    logic  s_wvalid;
    logic  s_wready;
    resp_t s_bresp;
    logic  s_bvalid;
    logic  s_bready;

    axi_arbiter u_arbiter (.*);

    axi_sram u_sram (.*);

endmodule

//--- hw/axi_sram.sv
`timescale 1ns/1ps
`include "axi_macros.svh"

module axi_sram (
    input  logic           clk,
    input  logic           rst,

    input  axi_pkg::addr_t s_araddr,
    input  logic           s_arvalid,
    output logic           s_arready,
    output axi_pkg::data_t s_rdata,
    output axi_pkg::resp_t s_rresp,
    output logic           s_rvalid,
    input  logic           s_rready,
    input  axi_pkg::addr_t s_awaddr,
    input  logic           s_awvalid,
    output logic           s_awready,
    input  axi_pkg::data_t s_wdata,
    input  axi_pkg::strb_t s_wstrb,
    input  logic           s_wvalid,
    output logic           s_wready,
    output axi_pkg::resp_t s_bresp,
    output logic           s_bvalid,
    input  logic           s_bready
);
    import axi_pkg::*;

    localparam int IDX_W = $clog2(`MEM_WORDS);

    typedef enum logic [1:0] {IDLE, RD_WAIT, WR_WAIT, RESP} sram_state_t;

    sram_state_t      state;
    data_t            mem [`MEM_WORDS];
    addr_t            addr_q;
    data_t            wdata_q;
    strb_t            wstrb_q;
    logic [IDX_W-1:0] idx;
    logic             in_range;
    logic             rd_accept;
    logic             wr_accept;
    logic             done;

    assign s_arready = (state == IDLE);
    assign s_awready = (state == IDLE) && !s_arvalid;   // reads win a tie.
    assign s_wready  = (state == IDLE) && !s_arvalid;

    assign rd_accept = (state == IDLE) && s_arvalid;
    assign wr_accept = (state == IDLE) && !s_arvalid && s_awvalid && s_wvalid;

    assign idx      = addr_q[IDX_W+1:2];
    assign in_range = (addr_q < addr_t'(`MEM_WORDS * 4));

    mem_delay_timer u_timer (
        .clk        (clk),
        .rst        (rst),
        .load       (rd_accept || wr_accept),
        .load_value (`TMR_W'(`MEM_LATENCY)),
        .done       (done)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            s_rvalid <= 1'b0;
            s_bvalid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (rd_accept) begin
                        state <= RD_WAIT;
                    end else if (wr_accept) begin
                        state <= WR_WAIT;
                    end
                end
                RD_WAIT: begin
                    if (done) begin
                        state    <= RESP;
                        s_rvalid <= 1'b1;
                    end
                end
                WR_WAIT: begin
                    if (done) begin
                        state    <= RESP;
                        s_bvalid <= 1'b1;
                    end
                end
                RESP: begin
                    if ((s_rvalid && s_rready) || (s_bvalid && s_bready)) begin
                        state    <= IDLE;
                        s_rvalid <= 1'b0;
                        s_bvalid <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            addr_q <= s_araddr;
        end else if (wr_accept) begin
            addr_q  <= s_awaddr;
            wdata_q <= s_wdata;
            wstrb_q <= s_wstrb;
        end
        if (done && state == RD_WAIT) begin
            s_rdata <= in_range ? mem[idx] : '0;
            s_rresp <= in_range ? RESP_OKAY : RESP_SLVERR;
        end
        if (done && state == WR_WAIT) begin
            s_bresp <= in_range ? RESP_OKAY : RESP_SLVERR;
            if (in_range) begin
                for (int b = 0; b < `STRB_W; b++) begin
                    if (wstrb_q[b]) begin
                        mem[idx][8*b +: 8] <= wdata_q[8*b +: 8];
                    end
                end
            end
        end
    end

    a_one_resp: assert property (@(posedge clk) disable iff (rst)
        !(s_rvalid && s_bvalid));
    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata));
    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp));

endmodule

//--- hw/axi_arbiter.sv
`timescale 1ns/1ps

module axi_arbiter (
    input  logic           clk,
    input  logic           rst,

    input  axi_pkg::addr_t m1_araddr,
    input  logic           m1_arvalid,
    output logic           m1_arready,
    output axi_pkg::data_t m1_rdata,
    output axi_pkg::resp_t m1_rresp,
    output logic           m1_rvalid,
    input  logic           m1_rready,
    input  axi_pkg::addr_t m1_awaddr,
    input  logic           m1_awvalid,
    output logic           m1_awready,
    input  axi_pkg::data_t m1_wdata,
    input  axi_pkg::strb_t m1_wstrb,
    input  logic           m1_wvalid,
    output logic           m1_wready,
    output axi_pkg::resp_t m1_bresp,
    output logic           m1_bvalid,
    input  logic           m1_bready,

    input  axi_pkg::addr_t m2_araddr,
    input  logic           m2_arvalid,
    output logic           m2_arready,
    output axi_pkg::data_t m2_rdata,
    output axi_pkg::resp_t m2_rresp,
    output logic           m2_rvalid,
    input  logic           m2_rready,
    input  axi_pkg::addr_t m2_awaddr,
    input  logic           m2_awvalid,
    output logic           m2_awready,
    input  axi_pkg::data_t m2_wdata,
    input  axi_pkg::strb_t m2_wstrb,
    input  logic           m2_wvalid,
    output logic           m2_wready,
    output axi_pkg::resp_t m2_bresp,
    output logic           m2_bvalid,
    input  logic           m2_bready,

    output axi_pkg::addr_t s_araddr,
    output logic           s_arvalid,
    input  logic           s_arready,
    input  axi_pkg::data_t s_rdata,
    input  axi_pkg::resp_t s_rresp,
    input  logic           s_rvalid,
    output logic           s_rready,
    output axi_pkg::addr_t s_awaddr,
    output logic           s_awvalid,
    input  logic           s_awready,
    output axi_pkg::data_t s_wdata,
    output axi_pkg::strb_t s_wstrb,
    output logic           s_wvalid,
    input  logic           s_wready,
    input  axi_pkg::resp_t s_bresp,
    input  logic           s_bvalid,
    output logic           s_bready
);
    import axi_pkg::*;
    import arb_pkg::*;

    mst_state_t m1_state;
    mst_state_t m2_state;
    mst_state_t owner_state;
    grant_t     grant;
    logic       m1_req;
    logic       m2_req;
    logic       m1_addr_hs;
    logic       m2_addr_hs;
    logic       m1_resp_hs;
    logic       m2_resp_hs;

    function automatic mst_state_t next_state(mst_state_t cur, logic req,
                                              logic addr_hs, logic resp_hs);
        mst_state_t nxt;
        nxt = cur;
        case (cur)
            ST_FREE: begin
                if (addr_hs) begin
                    nxt = ST_BUSY;   // granted and accepted at once.
                end else if (req) begin
                    nxt = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (addr_hs) begin
                    nxt = ST_BUSY;
                end
            end
            ST_BUSY: begin
                if (resp_hs) begin
                    nxt = ST_FREE;
                end
            end
            default: nxt = ST_FREE;
        endcase
        return nxt;
    endfunction

    assign m1_req     = m1_arvalid || (m1_awvalid && m1_wvalid);
    assign m2_req     = m2_arvalid || (m2_awvalid && m2_wvalid);
    assign m1_addr_hs = (m1_arvalid && m1_arready) ||
                        (m1_awvalid && m1_awready && m1_wvalid && m1_wready);
    assign m2_addr_hs = (m2_arvalid && m2_arready) ||
                        (m2_awvalid && m2_awready && m2_wvalid && m2_wready);
    assign m1_resp_hs = (m1_rvalid && m1_rready) || (m1_bvalid && m1_bready);
    assign m2_resp_hs = (m2_rvalid && m2_rready) || (m2_bvalid && m2_bready);

    assign owner_state = (grant == GRANT_M1) ? m1_state : m2_state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m1_state <= ST_FREE;
            m2_state <= ST_FREE;
        end else begin
            m1_state <= next_state(m1_state, m1_req, m1_addr_hs, m1_resp_hs);
            m2_state <= next_state(m2_state, m2_req, m2_addr_hs, m2_resp_hs);
        end
    end

    // an address handshake this cycle counts as busy, or the
    // response would follow the grant to the wrong master.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant <= GRANT_M1;
        end else if (owner_state != ST_BUSY && !(m1_addr_hs || m2_addr_hs)) begin
            if (m1_state == ST_WAIT) begin
                grant <= GRANT_M1;
            end else if (m2_state == ST_WAIT) begin
                grant <= GRANT_M2;
            end
        end
    end

    always_comb begin
        m1_arready = 1'b0;
        m1_rdata   = '0;
        m1_rresp   = RESP_OKAY;
        m1_rvalid  = 1'b0;
        m1_awready = 1'b0;
        m1_wready  = 1'b0;
        m1_bresp   = RESP_OKAY;
        m1_bvalid  = 1'b0;
        m2_arready = 1'b0;
        m2_rdata   = '0;
        m2_rresp   = RESP_OKAY;
        m2_rvalid  = 1'b0;
        m2_awready = 1'b0;
        m2_wready  = 1'b0;
        m2_bresp   = RESP_OKAY;
        m2_bvalid  = 1'b0;
        if (grant == GRANT_M1) begin
            s_araddr   = m1_araddr;
            s_arvalid  = m1_arvalid;
            s_rready   = m1_rready;
            s_awaddr   = m1_awaddr;
            s_awvalid  = m1_awvalid;
            s_wdata    = m1_wdata;
            s_wstrb    = m1_wstrb;
            s_wvalid   = m1_wvalid;
            s_bready   = m1_bready;
            m1_arready = s_arready;
            m1_rdata   = s_rdata;
            m1_rresp   = s_rresp;
            m1_rvalid  = s_rvalid;
            m1_awready = s_awready;
            m1_wready  = s_wready;
            m1_bresp   = s_bresp;
            m1_bvalid  = s_bvalid;
        end else begin
            s_araddr   = m2_araddr;
            s_arvalid  = m2_arvalid;
            s_rready   = m2_rready;
            s_awaddr   = m2_awaddr;
            s_awvalid  = m2_awvalid;
            s_wdata    = m2_wdata;
            s_wstrb    = m2_wstrb;
            s_wvalid   = m2_wvalid;
            s_bready   = m2_bready;
            m2_arready = s_arready;
            m2_rdata   = s_rdata;
            m2_rresp   = s_rresp;
            m2_rvalid  = s_rvalid;
            m2_awready = s_awready;
            m2_wready  = s_wready;
            m2_bresp   = s_bresp;
            m2_bvalid  = s_bvalid;
        end
    end

    // memory busy means the owner is mid transaction.
    a_grant_hold: assert property (@(posedge clk) disable iff (rst)
        !s_arready |=> $stable(grant));

    // a response reaches only the master that issued it.
    a_m1_resp_own: assert property (@(posedge clk) disable iff (rst)
        (m1_rvalid || m1_bvalid) |-> m1_state == ST_BUSY);
    a_m2_resp_own: assert property (@(posedge clk) disable iff (rst)
        (m2_rvalid || m2_bvalid) |-> m2_state == ST_BUSY);

endmodule

//--- hw/mem_delay_timer.sv
`timescale 1ns/1ps
`include "axi_macros.svh"

module mem_delay_timer (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  logic [`TMR_W-1:0] load_value,
    output logic              done
);

    logic [`TMR_W-1:0] count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // high in the last cycle of the count.
    assign done = (count == `TMR_W'(1));

    a_no_reload: assert property (@(posedge clk) disable iff (rst)
        load |-> count == '0);

endmodule

//--- hw/arb_pkg.sv
package arb_pkg;

    typedef enum logic [1:0] {
        ST_FREE = 2'd0,
        ST_WAIT = 2'd1,      // request raised, no address handshake yet.
        ST_BUSY = 2'd2       // address taken, response pending.
    } mst_state_t;

    typedef enum logic {
        GRANT_M1 = 1'b0,
        GRANT_M2 = 1'b1
    } grant_t;

endpackage

//--- hw/axi_pkg.sv
`include "axi_macros.svh"

package axi_pkg;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    typedef logic [`XLEN-1:0]   addr_t;
    typedef logic [`XLEN-1:0]   data_t;
    typedef logic [`STRB_W-1:0] strb_t;

endpackage

//--- hw/axi_macros.svh
`ifndef AXI_MACROS_SVH
`define AXI_MACROS_SVH

`define XLEN        32
`define STRB_W      (`XLEN / 8)
`define MEM_WORDS   256          // byte addresses below 1024 are valid.
`define MEM_LATENCY 3            // accept edge to response valid.
`define TMR_W       4

`endif
